// ==== files.f ====
+incdir+verification
design/bottom_pkg.sv
design/bottom_ctrl.sv
design/reg_file.sv
design/addr_regs.sv
design/inc_dec.sv
design/irq_unit.sv
design/cpu_bottom.sv
verification/tb_cpu_bottom.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cpu_bottom
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv) $(wildcard verification/*.sv*)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/tb_cases.svh ====
// Each row holds name, op, sel (register or pair index), db_in, res, irq_trig, ime,
// check kind and expected value. Pairs are BC=0 DE=1 HL=2 SP=3 PC=4 WZ=5 and register A is 6
add_case("ld_b", bottom_pkg::OP_LD_REG, 3'd0, 8'h5A, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0000);
add_case("st_b", bottom_pkg::OP_ST_REG, 3'd0, 8'h00, 8'h00, 5'h00, 1'b0, CK_DB_OUT, 16'h005A);
add_case("ld_res_a", bottom_pkg::OP_LD_RES, 3'd6, 8'h11, 8'hC3, 5'h00, 1'b0, CK_ALU_A, 16'h00C3);
add_case("ld_ir", bottom_pkg::OP_LD_IR, 3'd0, 8'h76, 8'h00, 5'h00, 1'b0, CK_IR, 16'h0076);
add_case("ld_z", bottom_pkg::OP_LD_Z, 3'd0, 8'h34, 8'h00, 5'h00, 1'b0, CK_TFLAGS, 16'h0003);
add_case("ld_w", bottom_pkg::OP_LD_W, 3'd0, 8'h12, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0000);
add_case("ld_hl_wz", bottom_pkg::OP_LD_PAIR_WZ, 3'd2, 8'h00, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0);
add_case("addr_hl", bottom_pkg::OP_ADDR, 3'd2, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1234);
// Latch shows the old value while the pair moves on
add_case("inc_hl", bottom_pkg::OP_INC, 3'd2, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1234);
add_case("addr_hl_inc", bottom_pkg::OP_ADDR, 3'd2, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1235);
add_case("dec_de", bottom_pkg::OP_DEC, 3'd1, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h0000);
add_case("addr_de_wrap", bottom_pkg::OP_ADDR, 3'd1, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'hFFFF);
add_case("ie_hit_on", bottom_pkg::OP_NOP, 3'd0, 8'h00, 8'h00, 5'h00, 1'b0, CK_IE_HIT, 16'h0001);
add_case("ld_z_ff", bottom_pkg::OP_LD_Z, 3'd0, 8'hFF, 8'h00, 5'h00, 1'b0, CK_TFLAGS, 16'h000F);
add_case("ld_bc_wz", bottom_pkg::OP_LD_PAIR_WZ, 3'd0, 8'h00, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0);
add_case("inc_lo_bc", bottom_pkg::OP_INC_LO, 3'd0, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h12FF);
add_case("addr_bc_lo", bottom_pkg::OP_ADDR, 3'd0, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1200);
// PC jump through W:Z
add_case("ld_z_80", bottom_pkg::OP_LD_Z, 3'd0, 8'h80, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0000);
add_case("ld_pc_wz", bottom_pkg::OP_LD_PAIR_WZ, 3'd4, 8'h00, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0);
add_case("addr_pc_jump", bottom_pkg::OP_ADDR, 3'd4, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1280);
add_case("addr_ie", bottom_pkg::OP_ADDR, 3'd1, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'hFFFF);
add_case("ie_write", bottom_pkg::OP_MEM_WR, 3'd0, 8'hF4, 8'h00, 5'h00, 1'b0, CK_IE_Q, 16'h0014);
add_case("addr_other", bottom_pkg::OP_ADDR, 3'd2, 8'h00, 8'h00, 5'h00, 1'b0, CK_IE_HIT, 16'h0);
add_case("ie_keep", bottom_pkg::OP_MEM_WR, 3'd0, 8'h1F, 8'h00, 5'h00, 1'b0, CK_IE_Q, 16'h0014);
// Interrupts with IE at 0x14
add_case("pend_ime_lo", bottom_pkg::OP_NOP, 3'd0, 8'h00, 8'h00, 5'h1C, 1'b0, CK_PEND, 16'h0000);
add_case("pend_ime_hi", bottom_pkg::OP_NOP, 3'd0, 8'h00, 8'h00, 5'h1C, 1'b1, CK_PEND, 16'h0001);
add_case("irq_take", bottom_pkg::OP_IRQ_TAKE, 3'd0, 8'h00, 8'h00, 5'h1C, 1'b1, CK_ACK, 16'h0004);
add_case("addr_pc_vec", bottom_pkg::OP_ADDR, 3'd4, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h0050);
// Move PC off the vector so a wrong take would show
add_case("ld_pc_back", bottom_pkg::OP_LD_PAIR_WZ, 3'd4, 8'h00, 8'h00, 5'h00, 1'b0, CK_NONE, 16'h0);
add_case("pend_masked", bottom_pkg::OP_NOP, 3'd0, 8'h00, 8'h00, 5'h1C, 1'b0, CK_PEND, 16'h0000);
add_case("take_masked", bottom_pkg::OP_IRQ_TAKE, 3'd0, 8'h00, 8'h00, 5'h1C, 1'b0, CK_ACK, 16'h0);
add_case("addr_pc_same", bottom_pkg::OP_ADDR, 3'd4, 8'h00, 8'h00, 5'h00, 1'b0, CK_ADDR, 16'h1280);

// ==== verification/tb_cpu_bottom.sv ====
`timescale 1ns/1ns

module tb_cpu_bottom;

	localparam int NUM_IRQ = 5;
	localparam int MAX_HALF = 4;	// Clock transitions allowed per edge wait
	localparam int RUN_LIMIT = 20000;	// Whole run in ns

	typedef enum int {
		CK_NONE,
		CK_DB_OUT,
		CK_ALU_A,
		CK_IR,
		CK_TFLAGS,
		CK_ADDR,
		CK_IE_Q,
		CK_IE_HIT,
		CK_PEND,
		CK_ACK
	} check_t;

	logic clk;
	logic rst;
	bottom_pkg::bottom_op_t op;
	bottom_pkg::reg_sel_t op_reg;
	bottom_pkg::pair_sel_t op_pair;
	bottom_pkg::byte_t db_in;
	bottom_pkg::byte_t res;
	logic [NUM_IRQ-1:0] irq_trig;
	logic ime;
	bottom_pkg::word_t addr;
	bottom_pkg::byte_t db_out;
	bottom_pkg::byte_t alu_a;
	bottom_pkg::byte_t ir;
	bottom_pkg::byte_t ie_q;
	logic [3:0] temp_flags;
	logic ie_hit;
	logic irq_pending;
	logic [NUM_IRQ-1:0] irq_ack;

	// Stimulus table columns
	string names[$];
	bottom_pkg::bottom_op_t ops[$];
	logic [2:0] sels[$];
	bottom_pkg::byte_t dbs[$];
	bottom_pkg::byte_t ress[$];
	logic [NUM_IRQ-1:0] trigs[$];
	logic imes[$];
	check_t kinds[$];
	bottom_pkg::word_t exps[$];

	cpu_bottom #(
		.NUM_IRQ (NUM_IRQ),
		.VEC_BASE(8'h40)
	) cpu_bottom_i (.clk, .rst, .op, .op_reg, .op_pair, .db_in, .res, .irq_trig, .ime, .addr,
		.db_out, .alu_a, .ir, .ie_q, .temp_flags, .ie_hit, .irq_pending, .irq_ack);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic add_case(input string name, input bottom_pkg::bottom_op_t o,
			input logic [2:0] sel, input bottom_pkg::byte_t db, input bottom_pkg::byte_t r,
			input logic [NUM_IRQ-1:0] trig, input logic ie_en, input check_t kind,
			input bottom_pkg::word_t exp);
		names.push_back(name);
		ops.push_back(o);
		sels.push_back(sel);
		dbs.push_back(db);
		ress.push_back(r);
		trigs.push_back(trig);
		imes.push_back(ie_en);
		kinds.push_back(kind);
		exps.push_back(exp);
	endtask

	task automatic build_table();
		`include "tb_cases.svh"
	endtask

	task automatic wait_rise();
		int n;
		n = 0;
		do begin
			@(clk);
			n++;
		end while (clk !== 1'b1 && n < MAX_HALF);
		if (clk !== 1'b1) begin
			$display("sim failed");
			$fatal(1, "Rising clock edge did not arrive in time");
		end
	endtask

	task automatic check_byte(input string name, input bottom_pkg::byte_t exp,
			input bottom_pkg::byte_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "Byte mismatch");
		end
	endtask

	task automatic check_word(input string name, input bottom_pkg::word_t exp,
			input bottom_pkg::word_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			$display("sim failed");
			$fatal(1, "Word mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			$display("sim failed");
			$fatal(1, "Status bit mismatch");
		end
	endtask

	task automatic check_irq(input string name, input logic [NUM_IRQ-1:0] exp,
			input logic [NUM_IRQ-1:0] act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			$display("sim failed");
			$fatal(1, "Acknowledge mismatch");
		end
	endtask

	// Hang guard for a stopped clock
	initial begin
		#(RUN_LIMIT);
		$display("sim failed");
		$fatal(1, "Run did not finish in time");
	end

	initial begin
		rst = 1'b1;
		op = bottom_pkg::OP_NOP;
		op_reg = bottom_pkg::REG_B;
		op_pair = bottom_pkg::PAIR_BC;
		db_in = '0;
		res = '0;
		irq_trig = '0;
		ime = 1'b0;
		build_table();
		repeat (4) wait_rise();
		#1 rst = 1'b0;
		check_word("reset_addr", 16'h0000, addr);
		for (int i = 0; i < names.size(); i++) begin
			op = ops[i];
			op_reg = bottom_pkg::reg_sel_t'(sels[i]);	// Same column serves both selects
			op_pair = bottom_pkg::pair_sel_t'(sels[i]);
			db_in = dbs[i];
			res = ress[i];
			irq_trig = trigs[i];
			ime = imes[i];
			wait_rise();
			#1;
			case (kinds[i])
				CK_DB_OUT: check_byte(names[i], exps[i][7:0], db_out);
				CK_ALU_A: check_byte(names[i], exps[i][7:0], alu_a);
				CK_IR: check_byte(names[i], exps[i][7:0], ir);
				CK_TFLAGS: check_byte(names[i], {4'h0, exps[i][3:0]}, {4'h0, temp_flags});
				CK_ADDR: check_word(names[i], exps[i], addr);
				CK_IE_Q: check_byte(names[i], exps[i][7:0], ie_q);
				CK_IE_HIT: check_bit(names[i], exps[i][0], ie_hit);
				CK_PEND: check_bit(names[i], exps[i][0], irq_pending);
				CK_ACK: check_irq(names[i], exps[i][NUM_IRQ-1:0], irq_ack);
				default: ;
			endcase
		end
		$display("sim passed");
		$finish;
	end

endmodule

// ==== design/cpu_bottom.sv ====
`timescale 1ns/1ns

module cpu_bottom #(
	parameter int                NUM_IRQ  = 5,
	parameter bottom_pkg::byte_t VEC_BASE = 8'h40
) (
	input  logic                   clk,
	input  logic                   rst,
	input  bottom_pkg::bottom_op_t op,
	input  bottom_pkg::reg_sel_t   op_reg,
	input  bottom_pkg::pair_sel_t  op_pair,
	input  bottom_pkg::byte_t      db_in,
	input  bottom_pkg::byte_t      res,
	input  logic [NUM_IRQ-1:0]     irq_trig,
	input  logic                   ime,
	output bottom_pkg::word_t      addr,
	output bottom_pkg::byte_t      db_out,
	output bottom_pkg::byte_t      alu_a,
	output bottom_pkg::byte_t      ir,
	output bottom_pkg::byte_t      ie_q,
	output logic [3:0]             temp_flags,
	output logic                   ie_hit,
	output logic                   irq_pending,
	output logic [NUM_IRQ-1:0]     irq_ack
);

	logic ir_wr;
	logic rf_wr;
	logic rf_src_res;
	logic st_wr;
	logic z_wr;
	logic w_wr;
	logic addr_wr;
	logic pair_ld_wz;
	logic ar_pair_wr;
	logic rf_pair_wr;
	logic ie_wr;
	logic irq_take;
	logic vec_ld;
	bottom_pkg::incdec_mode_t incdec_mode;
	bottom_pkg::word_t rf_pair;
	bottom_pkg::word_t addr_src;
	bottom_pkg::word_t incdec_out;	// Pair writeback value
	bottom_pkg::byte_t vec_addr;

	bottom_ctrl bottom_ctrl_i (.clk, .rst, .op, .op_pair, .ir_wr, .rf_wr, .rf_src_res, .st_wr,
		.z_wr, .w_wr, .addr_wr, .pair_ld_wz, .ar_pair_wr, .rf_pair_wr, .incdec_mode, .ie_wr,
		.irq_take);

	reg_file reg_file_i (.clk, .rst, .ir_wr, .rf_wr, .rf_src_res, .st_wr, .rf_pair_wr, .op_reg,
		.op_pair, .db_in, .res, .incdec_out, .rf_pair, .db_out, .ir, .alu_a);

	addr_regs addr_regs_i (.clk, .rst, .z_wr, .w_wr, .addr_wr, .pair_ld_wz, .ar_pair_wr, .vec_ld,
		.op_pair, .db_in, .rf_pair, .incdec_out, .vec_addr, .addr, .addr_src, .temp_flags);

	inc_dec inc_dec_i (.clk, .mode(incdec_mode), .addr_src, .incdec_out);

	irq_unit #(
		.NUM_IRQ (NUM_IRQ),
		.VEC_BASE(VEC_BASE)
	) irq_unit_i (.clk, .rst, .ie_wr, .irq_take, .ime, .addr, .db_in, .irq_trig, .ie_q, .ie_hit,
		.irq_pending, .vec_ld, .vec_addr, .irq_ack);

endmodule

// ==== design/irq_unit.sv ====
`timescale 1ns/1ns

module irq_unit #(
	parameter int                NUM_IRQ  = 5,
	parameter bottom_pkg::byte_t VEC_BASE = 8'h40
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               ie_wr,
	input  logic               irq_take,
	input  logic               ime,
	input  bottom_pkg::word_t  addr,
	input  bottom_pkg::byte_t  db_in,
	input  logic [NUM_IRQ-1:0] irq_trig,
	output bottom_pkg::byte_t  ie_q,
	output logic               ie_hit,
	output logic               irq_pending,
	output logic               vec_ld,
	output bottom_pkg::byte_t  vec_addr,
	output logic [NUM_IRQ-1:0] irq_ack
);

	logic [NUM_IRQ-1:0] ie;
	logic [NUM_IRQ-1:0] if_q;	// Interrupt flags
	logic [NUM_IRQ-1:0] grant;

	assign ie_hit = (addr == bottom_pkg::IE_ADDR);
	assign ie_q = bottom_pkg::byte_t'(ie);	// Unused upper bits read 0

	assign irq_pending = (|if_q) && ime;
	assign vec_ld = irq_take && irq_pending;	// PC loads on the take edge

	// Lowest set flag wins
	assign grant = if_q & (~if_q + NUM_IRQ'(1));

	always_comb begin
		vec_addr = VEC_BASE;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (if_q[i])
				vec_addr = bottom_pkg::byte_t'(VEC_BASE + i * bottom_pkg::VEC_STEP);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ie <= '0;
			if_q <= '0;
			irq_ack <= '0;
		end else begin
			if (ie_wr && ie_hit)
				ie <= db_in[NUM_IRQ-1:0];
			if_q <= irq_trig & ie;	// Sampled every cycle
			irq_ack <= vec_ld ? grant : '0;	// One-cycle pulse
		end
	end

	// An acknowledge is a single line and always follows a take
	a_ack_one: assert property (@(posedge clk) disable iff (rst)
		(irq_ack != '0) |-> $onehot(irq_ack) && $past(irq_take))
		else $error("irq_unit: bad acknowledge");

endmodule

// ==== design/inc_dec.sv ====
`timescale 1ns/1ns

module inc_dec (
	input  logic                     clk,
	input  bottom_pkg::incdec_mode_t mode,
	input  bottom_pkg::word_t        addr_src,
	output bottom_pkg::word_t        incdec_out
);

	logic down;
	logic lo_step;
	logic lo_carry;	// Carry or borrow out of the low byte
	logic hi_step;

	function automatic bottom_pkg::byte_t count_byte(input bottom_pkg::byte_t v,
			input logic en, input logic dn);
		if (!en)
			return v;
		return dn ? v - 8'd1 : v + 8'd1;
	endfunction

	assign down = (mode == bottom_pkg::ID_DEC);
	assign lo_step = (mode != bottom_pkg::ID_PASS);
	assign lo_carry = lo_step && (down ? (addr_src[7:0] == 8'h00) : (addr_src[7:0] == 8'hFF));
	assign hi_step = lo_carry && (mode != bottom_pkg::ID_INC_LO);	// INC_LO cuts the chain

	assign incdec_out[7:0] = count_byte(addr_src[7:0], lo_step, down);
	assign incdec_out[15:8] = count_byte(addr_src[15:8], hi_step, down);

	a_mode_known: assert property (@(posedge clk) !$isunknown(mode))
		else $error("inc_dec: mode is unknown");

endmodule

// ==== design/addr_regs.sv ====
`timescale 1ns/1ns

module addr_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  z_wr,
	input  logic                  w_wr,
	input  logic                  addr_wr,
	input  logic                  pair_ld_wz,
	input  logic                  ar_pair_wr,
	input  logic                  vec_ld,
	input  bottom_pkg::pair_sel_t op_pair,
	input  bottom_pkg::byte_t     db_in,
	input  bottom_pkg::word_t     rf_pair,
	input  bottom_pkg::word_t     incdec_out,
	input  bottom_pkg::byte_t     vec_addr,
	output bottom_pkg::word_t     addr,
	output bottom_pkg::word_t     addr_src,
	output logic [3:0]            temp_flags
);

	bottom_pkg::byte_t z;	// Temp low
	bottom_pkg::byte_t w;	// Temp high
	bottom_pkg::word_t sp;
	bottom_pkg::word_t pc;

	// Source for the address latch and the inc/dec unit
	always_comb begin
		if (pair_ld_wz) begin
			addr_src = {w, z};
		end else begin
			case (op_pair)
				bottom_pkg::PAIR_SP: addr_src = sp;
				bottom_pkg::PAIR_PC: addr_src = pc;
				bottom_pkg::PAIR_WZ: addr_src = {w, z};
				default: addr_src = rf_pair;	// BC, DE, HL from reg_file
			endcase
		end
	end

	assign temp_flags = z[7:4];	// Z N H C from the temp Z register

	always_ff @(posedge clk) begin
		if (rst) begin
			z <= '0;
			w <= '0;
			sp <= '0;
			pc <= '0;
			addr <= '0;
		end else begin
			if (z_wr)
				z <= db_in;
			if (w_wr)
				w <= db_in;
			if (addr_wr)
				addr <= addr_src;	// Old pair value goes out
			if (ar_pair_wr) begin
				case (op_pair)
					bottom_pkg::PAIR_SP: sp <= incdec_out;
					bottom_pkg::PAIR_PC: pc <= incdec_out;
					bottom_pkg::PAIR_WZ: begin
						w <= incdec_out[15:8];
						z <= incdec_out[7:0];
					end
					default: ;
				endcase
			end
			// Interrupt vector wins over any PC write
			if (vec_ld)
				pc <= {8'h00, vec_addr};
		end
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ir_wr,
	input  logic                  rf_wr,
	input  logic                  rf_src_res,
	input  logic                  st_wr,
	input  logic                  rf_pair_wr,
	input  bottom_pkg::reg_sel_t  op_reg,
	input  bottom_pkg::pair_sel_t op_pair,
	input  bottom_pkg::byte_t     db_in,
	input  bottom_pkg::byte_t     res,
	input  bottom_pkg::word_t     incdec_out,
	output bottom_pkg::word_t     rf_pair,
	output bottom_pkg::byte_t     db_out,
	output bottom_pkg::byte_t     ir,
	output bottom_pkg::byte_t     alu_a
);

	bottom_pkg::byte_t gpr [7];	// B C D E H L A
	bottom_pkg::byte_t ld_val;
	logic [2:0] hi_idx;
	logic [2:0] lo_idx;
	logic pair_ok;
	logic reg_ok;

	assign ld_val = rf_src_res ? res : db_in;

	// BC, DE, HL map onto register index 2p and 2p+1
	assign hi_idx = {op_pair[1:0], 1'b0};
	assign lo_idx = {op_pair[1:0], 1'b1};
	assign pair_ok = (op_pair == bottom_pkg::PAIR_BC) || (op_pair == bottom_pkg::PAIR_DE) ||
		(op_pair == bottom_pkg::PAIR_HL);
	assign reg_ok = (op_reg <= bottom_pkg::REG_A);

	always_comb begin
		rf_pair = '0;
		if (pair_ok)
			rf_pair = {gpr[hi_idx], gpr[lo_idx]};	// High register first
	end

	assign alu_a = gpr[bottom_pkg::REG_A];	// Operand 1 is always A

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 7; i++)
				gpr[i] <= '0;
			ir <= '0;
			db_out <= '0;
		end else begin
			if (ir_wr)
				ir <= db_in;
			if (rf_wr && reg_ok)
				gpr[op_reg] <= ld_val;
			if (rf_pair_wr && pair_ok) begin
				gpr[hi_idx] <= incdec_out[15:8];
				gpr[lo_idx] <= incdec_out[7:0];
			end
			if (st_wr && reg_ok)
				db_out <= gpr[op_reg];	// Store latch toward memory
		end
	end

endmodule

// ==== design/bottom_ctrl.sv ====
`timescale 1ns/1ns

module bottom_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  bottom_pkg::bottom_op_t   op,
	input  bottom_pkg::pair_sel_t    op_pair,
	output logic                     ir_wr,
	output logic                     rf_wr,
	output logic                     rf_src_res,
	output logic                     st_wr,
	output logic                     z_wr,
	output logic                     w_wr,
	output logic                     addr_wr,
	output logic                     pair_ld_wz,
	output logic                     ar_pair_wr,
	output logic                     rf_pair_wr,
	output bottom_pkg::incdec_mode_t incdec_mode,
	output logic                     ie_wr,
	output logic                     irq_take
);

	logic pair_wr;	// Some pair takes the inc/dec result
	logic pair_in_rf;
	logic pair_in_ar;

	assign pair_in_rf = (op_pair == bottom_pkg::PAIR_BC) || (op_pair == bottom_pkg::PAIR_DE) ||
		(op_pair == bottom_pkg::PAIR_HL);
	assign pair_in_ar = (op_pair == bottom_pkg::PAIR_SP) || (op_pair == bottom_pkg::PAIR_PC) ||
		(op_pair == bottom_pkg::PAIR_WZ);

	always_comb begin
		ir_wr = 1'b0;
		rf_wr = 1'b0;
		rf_src_res = 1'b0;
		st_wr = 1'b0;
		z_wr = 1'b0;
		w_wr = 1'b0;
		addr_wr = 1'b0;
		pair_ld_wz = 1'b0;
		pair_wr = 1'b0;
		incdec_mode = bottom_pkg::ID_PASS;
		ie_wr = 1'b0;
		irq_take = 1'b0;
		case (op)
			bottom_pkg::OP_LD_IR: ir_wr = 1'b1;
			bottom_pkg::OP_LD_REG: rf_wr = 1'b1;
			bottom_pkg::OP_LD_RES: begin
				rf_wr = 1'b1;
				rf_src_res = 1'b1;
			end
			bottom_pkg::OP_ST_REG: st_wr = 1'b1;
			bottom_pkg::OP_LD_Z: z_wr = 1'b1;
			bottom_pkg::OP_LD_W: w_wr = 1'b1;
			bottom_pkg::OP_LD_PAIR_WZ: begin
				pair_ld_wz = 1'b1;	// W:Z passes through inc_dec unchanged
				pair_wr = 1'b1;
			end
			bottom_pkg::OP_ADDR: addr_wr = 1'b1;
			bottom_pkg::OP_INC: begin
				addr_wr = 1'b1;
				pair_wr = 1'b1;
				incdec_mode = bottom_pkg::ID_INC;
			end
			bottom_pkg::OP_DEC: begin
				addr_wr = 1'b1;
				pair_wr = 1'b1;
				incdec_mode = bottom_pkg::ID_DEC;
			end
			bottom_pkg::OP_INC_LO: begin
				addr_wr = 1'b1;
				pair_wr = 1'b1;
				incdec_mode = bottom_pkg::ID_INC_LO;
			end
			bottom_pkg::OP_MEM_WR: ie_wr = 1'b1;	// irq_unit decodes the address
			bottom_pkg::OP_IRQ_TAKE: irq_take = 1'b1;
			default: ;
		endcase
	end

	assign rf_pair_wr = pair_wr && pair_in_rf;	// BC, DE, HL
	assign ar_pair_wr = pair_wr && pair_in_ar;	// SP, PC, WZ

	a_op_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(op))
		else $error("bottom_ctrl: op is unknown");
	a_pair_wr_one: assert property (@(posedge clk) disable iff (rst)
		pair_wr |-> $onehot({rf_pair_wr, ar_pair_wr}))
		else $error("bottom_ctrl: pair write has no single target");
	a_mem_wr_excl: assert property (@(posedge clk) disable iff (rst)
		ie_wr |-> !(rf_pair_wr || ar_pair_wr))
		else $error("bottom_ctrl: memory write with pair write");

endmodule

// ==== design/bottom_pkg.sv ====
package bottom_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;

	// Byte register select where B..L follow the pair order
	typedef enum logic [2:0] {
		REG_B,
		REG_C,
		REG_D,
		REG_E,
		REG_H,
		REG_L,
		REG_A
	} reg_sel_t;

	typedef enum logic [2:0] {
		PAIR_BC,
		PAIR_DE,
		PAIR_HL,
		PAIR_SP,
		PAIR_PC,
		PAIR_WZ
	} pair_sel_t;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_LD_IR,
		OP_LD_REG,	// Register from db_in
		OP_LD_RES,	// Register from ALU result
		OP_ST_REG,	// Register to db_out
		OP_LD_Z,
		OP_LD_W,
		OP_LD_PAIR_WZ,	// Pair takes W:Z
		OP_ADDR,	// Address latch takes pair
		OP_INC,
		OP_DEC,
		OP_INC_LO,	// Low byte only, high byte kept
		OP_MEM_WR,
		OP_IRQ_TAKE
	} bottom_op_t;

	typedef enum logic [1:0] {
		ID_PASS,
		ID_INC,
		ID_DEC,
		ID_INC_LO
	} incdec_mode_t;

	localparam word_t IE_ADDR = 16'hFFFF;	// IE mapped here
	localparam int VEC_STEP = 8;	// Spacing of interrupt vectors

endpackage
